// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := ram_tile_tb
FILELIST  := ram_flops_tile.f
OBJ_DIR   := obj_dir
LOG       := sim.log
SOURCES   := $(wildcard design/*.sv design/*.svh sim/*.sv)

.PHONY: all run lint clean

all: run

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# The log decides the result, whatever the simulator exit status
run: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -qF "*** TEST PASSED ***" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== design/ram_flops_tile.sv ====
// --------------------------------------
// 2W/2R flop RAM, 16x32 with byte enables. Read in same cycle, write in one
// --------------------------------------
`include "ram_tile_defines.svh"

module ram_flops_tile
  import ram_store_pkg::*;
  import ram_port_pkg::*;
#(
  // Same-cycle write to read forwarding
  parameter bit enable_bypass = 1'b1
) (
  input  logic                                  wr_clk,
  input  logic                                  wr_rst,
  input  ram_wr_req_t  [`RAM_NUM_WR-1:0]        wr_req,
  input  ram_rd_req_t  [`RAM_NUM_RD-1:0]        rd_req,
  output ram_rd_resp_t [`RAM_NUM_RD-1:0]        rd_resp
);

  // Decoded write command for each row
  ram_row_wr_t [`RAM_DEPTH-1:0] row_wr;

  // Current contents of each row, fed to the read mux
  ram_data_t [`RAM_DEPTH-1:0] row_data;

  // Port-to-row write steering
  ram_wr_steer ram_wr_steer_inst (
    .wr_clk (wr_clk),
    .wr_rst (wr_rst),
    .wr_req (wr_req),
    .row_wr (row_wr)
  );

  // --------------------------------------
  // Row array
  // --------------------------------------
  for (genvar i = 0; i < `RAM_DEPTH; i++) begin : gen_rows
    ram_row ram_row_inst (
      .wr_clk   (wr_clk),
      .wr_rst   (wr_rst),
      .row_wr   (row_wr[i]),
      .row_data (row_data[i])
    );
  end

  // Read ports, with the raw write requests for forwarding
  ram_rd_mux #(
    .enable_bypass (enable_bypass)
  ) ram_rd_mux_inst (
    .wr_clk  (wr_clk),
    .wr_rst  (wr_rst),
    .rows    (row_data),
    .wr_req  (wr_req),
    .rd_req  (rd_req),
    .rd_resp (rd_resp)
  );

endmodule

// ==== design/ram_port_pkg.sv ====
// --------------------------------------
// External port types. Valid-only handshake with no back-pressure
// --------------------------------------
`include "ram_tile_defines.svh"

package ram_port_pkg;
  import ram_store_pkg::*;

  // Row address as seen on every port
  typedef logic [`RAM_ADDR_W-1:0] ram_addr_t;

  // Write request, counted in every cycle where valid is high
  // Only the words with a set bit in word_en are written
  typedef struct packed {
    logic         valid;
    ram_addr_t    addr;
    ram_word_en_t word_en;
    ram_data_t    data;
  } ram_wr_req_t;

  // Read request, answered combinationally in the same cycle
  typedef struct packed {
    logic      valid;
    ram_addr_t addr;
  } ram_rd_req_t;

  // Read response, valid mirrors the request valid
  typedef struct packed {
    logic      valid;
    ram_data_t data;
  } ram_rd_resp_t;

endpackage

// ==== design/ram_rd_mux.sv ====
// --------------------------------------
// Bypass adds a combinational path from write ports to read data
// --------------------------------------
`include "ram_tile_defines.svh"

module ram_rd_mux
  import ram_store_pkg::*;
  import ram_port_pkg::*;
#(
  // 1 forwards same-cycle write words, 0 returns the value before the write
  parameter bit enable_bypass = 1'b1
) (
  input  logic                                  wr_clk,
  input  logic                                  wr_rst,
  input  ram_data_t    [`RAM_DEPTH-1:0]         rows,
  input  ram_wr_req_t  [`RAM_NUM_WR-1:0]        wr_req,
  input  ram_rd_req_t  [`RAM_NUM_RD-1:0]        rd_req,
  output ram_rd_resp_t [`RAM_NUM_RD-1:0]        rd_resp
);

  // Row picked by each read address before any forwarding
  ram_data_t [`RAM_NUM_RD-1:0] stored_data;

  // Which write ports hit each read port's address this cycle
  logic [`RAM_NUM_RD-1:0][`RAM_NUM_WR-1:0] wr_match;

  // --------------------------------------
  // Row select and address compare
  // --------------------------------------

  always_comb begin
    for (int rp = 0; rp < `RAM_NUM_RD; rp++) begin
      stored_data[rp] = rows[rd_req[rp].addr];
      for (int wp = 0; wp < `RAM_NUM_WR; wp++) begin
        wr_match[rp][wp] = wr_req[wp].valid && (wr_req[wp].addr == rd_req[rp].addr);
      end
    end
  end

  // --------------------------------------
  // Merge and response
  // --------------------------------------

  // Start from the stored row and overlay enabled words of a matching write
  // Write ports never share an address, so at most one port matches
  always_comb begin
    for (int rp = 0; rp < `RAM_NUM_RD; rp++) begin
      rd_resp[rp].valid = rd_req[rp].valid;
      rd_resp[rp].data  = stored_data[rp];
      if (enable_bypass) begin
        for (int wp = 0; wp < `RAM_NUM_WR; wp++) begin
          for (int w = 0; w < `RAM_NUM_WORDS; w++) begin
            if (wr_match[rp][wp] && wr_req[wp].word_en[w]) begin
              rd_resp[rp].data[w] = wr_req[wp].data[w];
            end
          end
        end
      end
    end
  end

  // --------------------------------------
  // Checks
  // --------------------------------------

  // With forwarding, a full write to the read row replaces the whole word set
  // in the same cycle, regardless of what the row array holds
  if (enable_bypass) begin : gen_bypass_checks
    for (genvar rp = 0; rp < `RAM_NUM_RD; rp++) begin : gen_rd
      for (genvar wp = 0; wp < `RAM_NUM_WR; wp++) begin : gen_wr
        bypass_full_word_a : assert property (
          @(posedge wr_clk) disable iff (wr_rst)
          (rd_req[rp].valid && wr_match[rp][wp] && (&wr_req[wp].word_en))
            |-> (rd_resp[rp].data == wr_req[wp].data)
        ) else $error("Read port %0d missed bypass from write port %0d", rp, wp);
      end
    end
  end

endmodule

// ==== design/ram_row.sv ====
// --------------------------------------
// One row of flops. Reset always clears the stored words
// --------------------------------------
`include "ram_tile_defines.svh"

module ram_row
  import ram_store_pkg::*;
(
  input  logic        wr_clk,
  input  logic        wr_rst,
  input  ram_row_wr_t row_wr,
  output ram_data_t   row_data
);

  // Stored words of this row
  ram_data_t row_q;

  // --------------------------------------
  // Storage
  // --------------------------------------

  // Each word loads on its own enable, others keep their value
  always_ff @(posedge wr_clk) begin
    if (wr_rst) begin
      row_q <= '0;
    end else if (row_wr.en) begin
      for (int w = 0; w < `RAM_NUM_WORDS; w++) begin
        if (row_wr.word_en[w]) begin
          row_q[w] <= row_wr.data[w];
        end
      end
    end
  end

  // Read side sees the flops directly, no output stage
  assign row_data = row_q;

  // --------------------------------------
  // Checks
  // --------------------------------------

  // A row nobody wrote must hold its contents into the next cycle
  row_stable_a : assert property (
    @(posedge wr_clk) disable iff (wr_rst)
    !row_wr.en |=> $stable(row_data)
  ) else $error("Row changed without a write enable");

endmodule

// ==== design/ram_store_pkg.sv ====
// --------------------------------------
// Storage-side types. Row layout is word 0 in the low byte
// --------------------------------------
`include "ram_tile_defines.svh"

package ram_store_pkg;

  // One write word, the smallest unit a partial write can change
  typedef logic [`RAM_WORD_W-1:0] ram_word_t;

  // A full row as packed words, so that row[i] picks word i
  typedef ram_word_t [`RAM_NUM_WORDS-1:0] ram_data_t;

  // One enable bit per word of a row
  typedef logic [`RAM_NUM_WORDS-1:0] ram_word_en_t;

  // Write command for a single row, already decoded from the ports
  // en says a port targets this row this cycle
  typedef struct packed {
    logic         en;
    ram_word_en_t word_en;
    ram_data_t    data;
  } ram_row_wr_t;

endpackage

// ==== design/ram_tile_defines.svh ====
// --------------------------------------
// Geometry of the RAM tile. RAM_WIDTH must equal RAM_WORD_W * RAM_NUM_WORDS
// and RAM_ADDR_W must cover RAM_DEPTH rows
// --------------------------------------
`ifndef RAM_TILE_DEFINES_SVH
`define RAM_TILE_DEFINES_SVH

// Number of rows in the tile
`define RAM_DEPTH 16

// Row address width, enough to index every row
`define RAM_ADDR_W 4

// Bits per row and bits per write word
`define RAM_WIDTH 32
`define RAM_WORD_W 8

// Words per row, one word-enable bit each
`define RAM_NUM_WORDS 4

// Number of independent write and read ports
`define RAM_NUM_WR 2
`define RAM_NUM_RD 2

`endif

// ==== design/ram_wr_steer.sv ====
// --------------------------------------
// Write ports must not share an address in one cycle. No arbitration is done
// --------------------------------------
`include "ram_tile_defines.svh"

module ram_wr_steer
  import ram_store_pkg::*;
  import ram_port_pkg::*;
(
  input  logic                                 wr_clk,
  input  logic                                 wr_rst,
  input  ram_wr_req_t [`RAM_NUM_WR-1:0]       wr_req,
  output ram_row_wr_t [`RAM_DEPTH-1:0]        row_wr
);

  // Hit matrix grouped by row, so each row sees which ports target it
  logic [`RAM_DEPTH-1:0][`RAM_NUM_WR-1:0] row_hit;

  // --------------------------------------
  // Address decode
  // --------------------------------------

  // Each valid port raises exactly one row bit
  always_comb begin
    for (int row = 0; row < `RAM_DEPTH; row++) begin
      for (int wp = 0; wp < `RAM_NUM_WR; wp++) begin
        row_hit[row][wp] = wr_req[wp].valid && (wr_req[wp].addr == ram_addr_t'(row));
      end
    end
  end

  // --------------------------------------
  // Per-row command build
  // --------------------------------------

  // At most one port hits a row, so an AND-OR select is enough
  // and no priority chain is built
  always_comb begin
    for (int row = 0; row < `RAM_DEPTH; row++) begin
      row_wr[row] = '0;
      for (int wp = 0; wp < `RAM_NUM_WR; wp++) begin
        if (row_hit[row][wp]) begin
          row_wr[row].word_en |= wr_req[wp].word_en;
          row_wr[row].data    |= wr_req[wp].data;
        end
      end
      // The row loads only when some port targets it
      row_wr[row].en = |row_hit[row];
    end
  end

  // --------------------------------------
  // Integration checks
  // --------------------------------------

  // Two ports on one address would OR their data into the row
  for (genvar pa = 0; pa < `RAM_NUM_WR - 1; pa++) begin : gen_conflict_a
    for (genvar pb = pa + 1; pb < `RAM_NUM_WR; pb++) begin : gen_conflict_b
      no_write_conflict_a : assert property (
        @(posedge wr_clk) disable iff (wr_rst)
        (wr_req[pa].valid && wr_req[pb].valid) |-> (wr_req[pa].addr != wr_req[pb].addr)
      ) else $error("Write ports %0d and %0d target the same row", pa, pb);
    end
  end

endmodule

// ==== ram_flops_tile.f ====
+incdir+design
design/ram_store_pkg.sv
design/ram_port_pkg.sv
design/ram_wr_steer.sv
design/ram_row.sv
design/ram_rd_mux.sv
design/ram_flops_tile.sv
sim/ram_tile_tb.sv

// ==== sim/ram_tile_tb.sv ====
// --------------------------------------
// Testbench for the RAM tile with bypass on. Stimulus never writes one
// address from both ports in a cycle, and every address stays in range
// --------------------------------------
`include "ram_tile_defines.svh"

module ram_tile_tb
  import ram_store_pkg::*;
  import ram_port_pkg::*;
();
  timeunit 1ns;
  timeprecision 100ps;

  // Half of the 40 ns clock period
  localparam int HALF_PERIOD = 20;
  // Cycles a wait loop may spend before the run is declared stuck
  localparam int TIMEOUT_CYCLES = 10;
  // The DUT and the reference model share this setting
  localparam bit BYPASS = 1'b1;
  localparam int RANDOM_CYCLES = 200;

  logic                           wr_clk = 1'b0;
  logic                           wr_rst;
  ram_wr_req_t  [`RAM_NUM_WR-1:0] wr_req;
  ram_rd_req_t  [`RAM_NUM_RD-1:0] rd_req;
  ram_rd_resp_t [`RAM_NUM_RD-1:0] rd_resp;

  // Reference memory, follows the DUT rows edge by edge
  ram_data_t shadow [`RAM_DEPTH];

  integer seed = 32'h9432_9040;
  int     pass_count = 0;
  int     fail_count = 0;
  int     sample_count = 0;
  int     target_sample = 0;
  int     test_num = 0;
  int     tests_failed = 0;
  int     test_fail_base;
  string  test_name;

  ram_flops_tile #(
    .enable_bypass (BYPASS)
  ) ram_flops_tile_inst (
    .wr_clk  (wr_clk),
    .wr_rst  (wr_rst),
    .wr_req  (wr_req),
    .rd_req  (rd_req),
    .rd_resp (rd_resp)
  );

  always #(HALF_PERIOD) wr_clk = ~wr_clk;

  // --------------------------------------
  // Reference model
  // --------------------------------------

  // Stored row with the enabled words of any same-cycle write laid over it
  function automatic ram_data_t ref_read(input ram_addr_t addr,
                                         input ram_wr_req_t [`RAM_NUM_WR-1:0] wr);
    ram_data_t result;
    result = shadow[addr];
    if (BYPASS) begin
      for (int wp = 0; wp < `RAM_NUM_WR; wp++) begin
        for (int w = 0; w < `RAM_NUM_WORDS; w++) begin
          if (wr[wp].valid && wr[wp].addr == addr && wr[wp].word_en[w]) begin
            result[w] = wr[wp].data[w];
          end
        end
      end
    end
    return result;
  endfunction

  // Same word-mask rule as the rows, applied once per rising edge
  task automatic update_shadow(input ram_wr_req_t [`RAM_NUM_WR-1:0] wr, input logic rst);
    if (rst) begin
      foreach (shadow[a]) begin
        shadow[a] = '0;
      end
    end else begin
      for (int wp = 0; wp < `RAM_NUM_WR; wp++) begin
        for (int w = 0; w < `RAM_NUM_WORDS; w++) begin
          if (wr[wp].valid && wr[wp].word_en[w]) begin
            shadow[wr[wp].addr][w] = wr[wp].data[w];
          end
        end
      end
    end
  endtask

  // --------------------------------------
  // Compare tasks
  // --------------------------------------

  task automatic check_data(input int port, input ram_data_t exp, input ram_data_t act);
    if (act !== exp) begin
      $display("ERROR %0t: read port %0d data expected %h got %h", $time, port, exp, act);
      fail_count++;
    end else begin
      pass_count++;
    end
  endtask

  task automatic check_valid(input int port, input logic exp, input logic act);
    if (act !== exp) begin
      $display("ERROR %0t: read port %0d valid expected %b got %b", $time, port, exp, act);
      fail_count++;
    end else begin
      pass_count++;
    end
  endtask

  // Samples 1 ns before each rising edge, when the combinational read path
  // has settled, then moves the shadow across the edge
  initial begin : compare_proc
    ram_wr_req_t [`RAM_NUM_WR-1:0] wr_seen;
    logic                          rst_seen;
    forever begin
      @(negedge wr_clk);
      #(HALF_PERIOD - 1);
      wr_seen  = wr_req;
      rst_seen = wr_rst;
      if (!rst_seen) begin
        for (int rp = 0; rp < `RAM_NUM_RD; rp++) begin
          check_valid(rp, rd_req[rp].valid, rd_resp[rp].valid);
          if (rd_req[rp].valid) begin
            check_data(rp, ref_read(rd_req[rp].addr, wr_seen), rd_resp[rp].data);
          end
        end
      end
      sample_count++;
      @(posedge wr_clk);
      update_shadow(wr_seen, rst_seen);
    end
  end

  // --------------------------------------
  // Stimulus helpers
  // --------------------------------------

  function automatic ram_wr_req_t make_write(input logic valid, input ram_addr_t addr,
                                             input ram_word_en_t word_en, input ram_data_t data);
    ram_wr_req_t req;
    req.valid   = valid;
    req.addr    = addr;
    req.word_en = word_en;
    req.data    = data;
    return req;
  endfunction

  function automatic ram_rd_req_t make_read(input logic valid, input ram_addr_t addr);
    ram_rd_req_t req;
    req.valid = valid;
    req.addr  = addr;
    return req;
  endfunction

  // One cycle of inputs, applied just after the rising edge
  task automatic drive_cycle(input ram_wr_req_t w0, input ram_wr_req_t w1,
                             input ram_rd_req_t r0, input ram_rd_req_t r1);
    @(posedge wr_clk);
    target_sample = sample_count + 1;
    wr_req[0] <= w0;
    wr_req[1] <= w1;
    rd_req[0] <= r0;
    rd_req[1] <= r1;
  endtask

  // Waits until the compare process has seen the last driven cycle
  task automatic drain_checks();
    int cycles;
    cycles = 0;
    while (sample_count < target_sample) begin
      if (cycles >= TIMEOUT_CYCLES) begin
        $display("Timeout: the compare process stopped sampling the read ports");
        $display("*** TEST FAILED ***");
        $finish;
      end
      @(posedge wr_clk);
      cycles++;
    end
  endtask

  task automatic start_test(input string name);
    test_name      = name;
    test_fail_base = fail_count;
    test_num++;
  endtask

  // Leaves the ports idle and reports this test's own error count
  task automatic end_test();
    int errs;
    drive_cycle(make_write(1'b0, 4'd0, 4'h0, '0), make_write(1'b0, 4'd0, 4'h0, '0),
                make_read(1'b0, 4'd0), make_read(1'b0, 4'd0));
    drain_checks();
    errs = fail_count - test_fail_base;
    if (errs != 0) begin
      tests_failed++;
    end
    $display("Test %0d %s: %s, %0d errors", test_num, test_name,
             (errs == 0) ? "ok" : "mismatch", errs);
  endtask

  // --------------------------------------
  // Tests
  // --------------------------------------

  task automatic test_reset_reads();
    ram_wr_req_t idle;
    idle = make_write(1'b0, 4'd0, 4'h0, '0);
    start_test("reset reads zero");
    // Port 1 toggles valid so the response valid is seen both ways
    for (int a = 0; a < `RAM_DEPTH; a++) begin
      drive_cycle(idle, idle, make_read(1'b1, ram_addr_t'(a)),
                  make_read(1'(a % 2), ram_addr_t'(`RAM_DEPTH - 1 - a)));
    end
    end_test();
  endtask

  task automatic test_full_writes();
    ram_addr_t   addrs [5];
    ram_wr_req_t idle;
    addrs = '{4'd0, 4'd3, 4'd7, 4'd11, 4'd15};
    idle  = make_write(1'b0, 4'd0, 4'h0, '0);
    start_test("full-mask writes");
    foreach (addrs[i]) begin
      drive_cycle(make_write(1'b1, addrs[i], 4'hF, ram_data_t'($random(seed))), idle,
                  make_read(1'b0, 4'd0), make_read(1'b0, 4'd0));
      drive_cycle(idle, idle, make_read(1'b1, addrs[i]), make_read(1'b1, addrs[i]));
    end
    // Second pass shows the rows still hold their data
    foreach (addrs[i]) begin
      drive_cycle(idle, idle, make_read(1'b1, addrs[i]), make_read(1'b1, addrs[4 - i]));
    end
    end_test();
  endtask

  task automatic test_partial_writes();
    ram_word_en_t masks [5];
    ram_wr_req_t  idle;
    masks = '{4'b0001, 4'b0110, 4'b1000, 4'b1010, 4'b0000};
    idle  = make_write(1'b0, 4'd0, 4'h0, '0);
    start_test("partial writes");
    drive_cycle(make_write(1'b1, 4'd5, 4'hF, 32'h1122_3344), idle,
                make_read(1'b0, 4'd0), make_read(1'b0, 4'd0));
    foreach (masks[i]) begin
      drive_cycle(idle, make_write(1'b1, 4'd5, masks[i], ram_data_t'($random(seed))),
                  make_read(1'b1, 4'd9), make_read(1'b0, 4'd0));
      drive_cycle(idle, idle, make_read(1'b1, 4'd5), make_read(1'b1, 4'd5));
    end
    end_test();
  endtask

  task automatic test_dual_writes();
    ram_addr_t   addr_a [3];
    ram_addr_t   addr_b [3];
    ram_wr_req_t idle;
    addr_a = '{4'd2, 4'd12, 4'd6};
    addr_b = '{4'd9, 4'd3, 4'd14};
    idle   = make_write(1'b0, 4'd0, 4'h0, '0);
    start_test("dual-port writes");
    foreach (addr_a[i]) begin
      drive_cycle(make_write(1'b1, addr_a[i], 4'hF, ram_data_t'($random(seed))),
                  make_write(1'b1, addr_b[i], 4'hF, ram_data_t'($random(seed))),
                  make_read(1'b0, 4'd0), make_read(1'b0, 4'd0));
      drive_cycle(idle, idle, make_read(1'b1, addr_a[i]), make_read(1'b1, addr_b[i]));
      drive_cycle(idle, idle, make_read(1'b1, addr_b[i]), make_read(1'b1, addr_a[i]));
    end
    end_test();
  endtask

  task automatic test_bypass();
    ram_wr_req_t idle;
    idle = make_write(1'b0, 4'd0, 4'h0, '0);
    start_test("same-cycle bypass");
    drive_cycle(make_write(1'b1, 4'd8, 4'hF, 32'hCAFE_F00D),
                make_write(1'b1, 4'd6, 4'hF, 32'hDEAD_BEEF),
                make_read(1'b0, 4'd0), make_read(1'b0, 4'd0));
    // Partial writes read in their own cycle merge with the old words
    drive_cycle(make_write(1'b1, 4'd8, 4'b1001, 32'hA1B2_C3D4),
                make_write(1'b1, 4'd6, 4'b0101, 32'h1234_5678),
                make_read(1'b1, 4'd6), make_read(1'b1, 4'd8));
    drive_cycle(make_write(1'b1, 4'd6, 4'hF, 32'h0F0F_0F0F), idle,
                make_read(1'b1, 4'd6), make_read(1'b1, 4'd6));
    drive_cycle(idle, idle, make_read(1'b1, 4'd6), make_read(1'b1, 4'd8));
    end_test();
  endtask

  task automatic test_random();
    ram_wr_req_t w0;
    ram_wr_req_t w1;
    ram_addr_t   a1;
    logic [31:0] r;
    start_test("random traffic");
    for (int n = 0; n < RANDOM_CYCLES; n++) begin
      r  = $random(seed);
      w0 = make_write(r[0] | r[1], r[7:4], r[11:8], ram_data_t'($random(seed)));
      r  = $random(seed);
      a1 = r[7:4];
      // Move port 1 off port 0's row so the two never collide
      if ((r[0] | r[1]) && w0.valid && a1 == w0.addr) begin
        a1 = a1 + 4'd1;
      end
      w1 = make_write(r[0] | r[1], a1, r[11:8], ram_data_t'($random(seed)));
      r  = $random(seed);
      drive_cycle(w0, w1, make_read(r[0] | r[5], r[1] ? w0.addr : r[7:4]),
                  make_read(r[2] | r[6], r[3] ? w1.addr : r[11:8]));
    end
    end_test();
  endtask

  // --------------------------------------
  // Main sequence
  // --------------------------------------
  initial begin
    wr_rst = 1'b1;
    wr_req = '0;
    rd_req = '0;
    repeat (2) @(posedge wr_clk);
    wr_rst <= 1'b0;

    test_reset_reads();
    test_full_writes();
    test_partial_writes();
    test_dual_writes();
    test_bypass();
    test_random();

    $display("Summary: %0d tests, %0d failed, %0d checks passed, %0d checks failed",
             test_num, tests_failed, pass_count, fail_count);
    if (fail_count == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule
